//--- design/loadAlign.sv
// load aligner picking a byte or halfword lane and extending it to a word
`timescale 1ns/1ps
`include "writeback_settings.svh"

module loadAlign (
    input  logic [1:0]                addrLow,
    input  wbPkg::LoadKindType        loadKind,
    input  logic [`WB_DATA_WIDTH-1:0] dmOut,
    output logic [`WB_DATA_WIDTH-1:0] loadData
);

    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // little-endian byte lanes
    always_comb begin
        case (addrLow)
            2'd0:    byteLane = dmOut[7:0];
            2'd1:    byteLane = dmOut[15:8];
            2'd2:    byteLane = dmOut[23:16];
            default: byteLane = dmOut[31:24];
        endcase
    end

    // halfword chosen by address bit 1
    // bit 0 assumed clear as misalignment traps upstream
    assign halfLane = addrLow[1] ? dmOut[31:16] : dmOut[15:0];

    always_comb begin
        case (loadKind)
            // lh
            wbPkg::LoadHalf:
                loadData = {{(`WB_DATA_WIDTH-16){halfLane[15]}}, halfLane};
            // lhu
            wbPkg::LoadHalfU:
                loadData = {{(`WB_DATA_WIDTH-16){1'b0}}, halfLane};
            // lb
            wbPkg::LoadByte:
                loadData = {{(`WB_DATA_WIDTH-8){byteLane[7]}}, byteLane};
            // lbu
            wbPkg::LoadByteU:
                loadData = {{(`WB_DATA_WIDTH-8){1'b0}}, byteLane};
            // lw and unused codes pass the word through
            default:
                loadData = dmOut;
        endcase
    end

endmodule

//--- design/mem2WbIf.sv
// memory-to-writeback bundle carrying the second memory cycle into writeback
`timescale 1ns/1ps
`include "writeback_settings.svh"

interface mem2WbIf;

    localparam int AddrWidth = $clog2(`WB_REG_COUNT);

    // instruction pc, used for link writeback
    logic [`WB_DATA_WIDTH-1:0] pc;
    // alu result, doubles as load address
    logic [`WB_DATA_WIDTH-1:0] result;
    // second operand
    logic [`WB_DATA_WIDTH-1:0] outB;
    // raw word from data memory
    logic [`WB_DATA_WIDTH-1:0] dmOut;
    // destination register
    logic [AddrWidth-1:0]      dst;
    wbPkg::WbSelType           wbSel;
    wbPkg::LoadKindType        loadKind;
    wbPkg::RegsWrType          regsWr;

    // memory stage side
    modport src (
        output pc, result, outB, dmOut, dst, wbSel, loadKind, regsWr
    );

    // writeback side
    modport snk (
        input pc, result, outB, dmOut, dst, wbSel, loadKind, regsWr
    );

endinterface

//--- design/regFile.sv
// general register file with hi and lo, one write port and two async reads
`timescale 1ns/1ps
`include "writeback_settings.svh"

module regFile (
    input  logic                      clk,
    input  logic                      rst,
    input  wbPkg::RegsWrType          wrType,
    input  logic [4:0]                wrAddr,
    input  logic [`WB_DATA_WIDTH-1:0] wrData,
    input  logic [4:0]                rdAddrA,
    input  logic [4:0]                rdAddrB,
    output logic [`WB_DATA_WIDTH-1:0] rdDataA,
    output logic [`WB_DATA_WIDTH-1:0] rdDataB,
    output logic [`WB_DATA_WIDTH-1:0] hi,
    output logic [`WB_DATA_WIDTH-1:0] lo
);

    logic [`WB_DATA_WIDTH-1:0] regs [`WB_REG_COUNT];

    // general registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `WB_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
        // $zero is never written
        else if (wrType.rfWr && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // hi and lo share the write data
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end
        else begin
            if (wrType.hiWr) begin
                hi <= wrData;
            end
            if (wrType.loWr) begin
                lo <= wrData;
            end
        end
    end

    // async reads, no bypass of the write in progress
    // register 0 forced to zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- design/wbPkg.sv
// writeback stage types for write flags, result source and load kind
package wbPkg;

    // destinations written by one instruction
    // all zero means nothing to commit
    typedef struct packed {
        // general register file
        logic rfWr;
        // hi register
        logic hiWr;
        // lo register
        logic loWr;
    } RegsWrType;

    // source of the writeback result
    typedef enum logic [1:0] {
        // pc plus link offset for jal and jalr
        SelLink = 2'd0,
        // alu result
        SelAlu  = 2'd1,
        // second operand, used by mthi and mtlo
        SelOutB = 2'd2,
        // aligned load data
        SelLoad = 2'd3
    } WbSelType;

    // load width and signedness
    // decoded earlier in the pipe
    typedef enum logic [2:0] {
        LoadWord  = 3'd0,
        LoadHalf  = 3'd1,
        LoadHalfU = 3'd2,
        LoadByte  = 3'd3,
        LoadByteU = 3'd4
    } LoadKindType;

endpackage

//--- design/wbReg.sv
// writeback pipeline register with synchronous reset, flush and stall
`timescale 1ns/1ps
`include "writeback_settings.svh"

module wbReg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      wr,
    mem2WbIf.snk                      in,
    output logic [`WB_DATA_WIDTH-1:0] wbPc,
    output logic [`WB_DATA_WIDTH-1:0] wbResult,
    output logic [`WB_DATA_WIDTH-1:0] wbOutB,
    output logic [`WB_DATA_WIDTH-1:0] wbDmOut,
    output logic [4:0]                wbDst,
    output wbPkg::WbSelType           wbSel,
    output wbPkg::LoadKindType        wbLoadKind,
    output wbPkg::RegsWrType          wbRegsWr
);

    always_ff @(posedge clk) begin
        // flush and reset both empty the stage
        if (flush || rst) begin
            wbPc       <= '0;
            wbResult   <= '0;
            wbOutB     <= '0;
            wbDmOut    <= '0;
            wbDst      <= '0;
            wbSel      <= wbPkg::SelLink;
            wbLoadKind <= wbPkg::LoadWord;
            // no write pending afterwards
            wbRegsWr   <= '0;
        end
        // wr low means stall, hold everything
        else if (wr) begin
            wbPc       <= in.pc;
            wbResult   <= in.result;
            wbOutB     <= in.outB;
            wbDmOut    <= in.dmOut;
            wbDst      <= in.dst;
            wbSel      <= in.wbSel;
            wbLoadKind <= in.loadKind;
            wbRegsWr   <= in.regsWr;
        end
    end

endmodule

//--- design/wbStage.sv
// writeback stage selecting the result and gating the commit on cache stall
`timescale 1ns/1ps
`include "writeback_settings.svh"

module wbStage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      wr,
    input  logic                      disWr,
    mem2WbIf.snk                      m2Wb,
    output logic [`WB_DATA_WIDTH-1:0] wbPc,
    output logic [4:0]                wbDst,
    output logic [`WB_DATA_WIDTH-1:0] wbResult,
    output wbPkg::RegsWrType          wbFinalWr
);

    logic [`WB_DATA_WIDTH-1:0] aluResult;
    logic [`WB_DATA_WIDTH-1:0] regOutB;
    logic [`WB_DATA_WIDTH-1:0] regDmOut;
    logic [`WB_DATA_WIDTH-1:0] loadData;
    wbPkg::WbSelType           regSel;
    wbPkg::LoadKindType        regLoadKind;
    wbPkg::RegsWrType          regRegsWr;

    wbReg wbReg_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .wr         (wr),
        .in         (m2Wb),
        .wbPc       (wbPc),
        .wbResult   (aluResult),
        .wbOutB     (regOutB),
        .wbDmOut    (regDmOut),
        .wbDst      (wbDst),
        .wbSel      (regSel),
        .wbLoadKind (regLoadKind),
        .wbRegsWr   (regRegsWr)
    );

    // alu result low bits are the load address
    loadAlign loadAlign_i (
        .addrLow  (aluResult[1:0]),
        .loadKind (regLoadKind),
        .dmOut    (regDmOut),
        .loadData (loadData)
    );

    always_comb begin
        case (regSel)
            wbPkg::SelLink: wbResult = wbPc + `WB_LINK_OFFSET;
            wbPkg::SelAlu:  wbResult = aluResult;
            wbPkg::SelOutB: wbResult = regOutB;
            default:        wbResult = loadData;
        endcase
    end

    // dcache stall blocks every destination for this cycle
    assign wbFinalWr = disWr ? '0 : regRegsWr;

endmodule

//--- design/wbTop.sv
// writeback subsystem top joining the stage and the register file
`timescale 1ns/1ps
`include "writeback_settings.svh"

module wbTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      wr,
    input  logic                      disWr,
    input  logic [`WB_DATA_WIDTH-1:0] mem2Pc,
    input  logic [`WB_DATA_WIDTH-1:0] mem2Result,
    input  logic [`WB_DATA_WIDTH-1:0] mem2OutB,
    input  logic [`WB_DATA_WIDTH-1:0] mem2DmOut,
    input  logic [4:0]                mem2Dst,
    input  wbPkg::WbSelType           mem2WbSel,
    input  wbPkg::LoadKindType        mem2LoadKind,
    input  wbPkg::RegsWrType          mem2RegsWr,
    input  logic [4:0]                rdAddrA,
    input  logic [4:0]                rdAddrB,
    output logic [`WB_DATA_WIDTH-1:0] wbPc,
    output logic [`WB_DATA_WIDTH-1:0] wbResult,
    output logic [4:0]                wbDst,
    output wbPkg::RegsWrType          wbFinalWr,
    output logic [`WB_DATA_WIDTH-1:0] rdDataA,
    output logic [`WB_DATA_WIDTH-1:0] rdDataB,
    output logic [`WB_DATA_WIDTH-1:0] hi,
    output logic [`WB_DATA_WIDTH-1:0] lo
);

    mem2WbIf m2WbBus ();

    // memory stage side of the bundle
    assign m2WbBus.pc       = mem2Pc;
    assign m2WbBus.result   = mem2Result;
    assign m2WbBus.outB     = mem2OutB;
    assign m2WbBus.dmOut    = mem2DmOut;
    assign m2WbBus.dst      = mem2Dst;
    assign m2WbBus.wbSel    = mem2WbSel;
    assign m2WbBus.loadKind = mem2LoadKind;
    assign m2WbBus.regsWr   = mem2RegsWr;

    wbStage wbStage_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .wr        (wr),
        .disWr     (disWr),
        .m2Wb      (m2WbBus),
        .wbPc      (wbPc),
        .wbDst     (wbDst),
        .wbResult  (wbResult),
        .wbFinalWr (wbFinalWr)
    );

    // commit target, written with the gated flags
    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .wrType  (wbFinalWr),
        .wrAddr  (wbDst),
        .wrData  (wbResult),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .hi      (hi),
        .lo      (lo)
    );

endmodule

//--- design/writeback_settings.svh
// writeback stage sizing constants shared by the design and the testbench
`ifndef WRITEBACK_SETTINGS_SVH
`define WRITEBACK_SETTINGS_SVH

// data path width in bits
`define WB_DATA_WIDTH 32

// general registers in the register file
// five address bits for thirty-two entries
`define WB_REG_COUNT 32

// pc increment written back by link instructions
// skips the branch delay slot
`define WB_LINK_OFFSET 8

`endif

//--- run.sh
#!/usr/bin/env bash
# compile and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f wbTop.f --top-module wbTopTb -Mdir "$OBJ" -o wbTopSim
if [ $? -ne 0 ]; then
    echo "compile step returned an error"
    exit 1
fi

"./$OBJ/wbTopSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi

exit 0

//--- tests/wbTopTb.sv
// writeback subsystem testbench with random stimulus and a pipeline and register model
`timescale 1ns/1ps
`include "writeback_settings.svh"

module wbTopTb;

    localparam int RandCycles = 2000;
    // reset, sweep and random phase with margin
    localparam int MaxCycles  = 2600;

    logic clk;
    logic rst;
    logic flush;
    logic wr;
    logic disWr;
    logic [31:0] mem2Pc;
    logic [31:0] mem2Result;
    logic [31:0] mem2OutB;
    logic [31:0] mem2DmOut;
    logic [4:0] mem2Dst;
    wbPkg::WbSelType mem2WbSel;
    wbPkg::LoadKindType mem2LoadKind;
    wbPkg::RegsWrType mem2RegsWr;
    logic [4:0] rdAddrA;
    logic [4:0] rdAddrB;
    logic [31:0] wbPc;
    logic [31:0] wbResult;
    logic [4:0] wbDst;
    wbPkg::RegsWrType wbFinalWr;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] hi;
    logic [31:0] lo;

    // model of the writeback register
    logic [31:0] mPc;
    logic [31:0] mResult;
    logic [31:0] mOutB;
    logic [31:0] mDmOut;
    logic [4:0] mDst;
    logic [1:0] mSel;
    logic [2:0] mKind;
    // rfWr, hiWr, loWr in struct order
    logic [2:0] mWr;
    // shadow register file
    logic [31:0] shadow [32];
    logic [31:0] shadowHi;
    logic [31:0] shadowLo;

    integer seed;
    int errCount;
    int checkCount;
    logic done;

    wbTop dut_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .wr           (wr),
        .disWr        (disWr),
        .mem2Pc       (mem2Pc),
        .mem2Result   (mem2Result),
        .mem2OutB     (mem2OutB),
        .mem2DmOut    (mem2DmOut),
        .mem2Dst      (mem2Dst),
        .mem2WbSel    (mem2WbSel),
        .mem2LoadKind (mem2LoadKind),
        .mem2RegsWr   (mem2RegsWr),
        .rdAddrA      (rdAddrA),
        .rdAddrB      (rdAddrB),
        .wbPc         (wbPc),
        .wbResult     (wbResult),
        .wbDst        (wbDst),
        .wbFinalWr    (wbFinalWr),
        .rdDataA      (rdDataA),
        .rdDataB      (rdDataB),
        .hi           (hi),
        .lo           (lo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected writeback value from the model register
    function automatic logic [31:0] expectedResult();
        logic [15:0] half;
        logic [7:0] lane;
        logic [31:0] res;
        half = mResult[1] ? mDmOut[31:16] : mDmOut[15:0];
        // byte offset times eight picks the lane
        lane = mDmOut[{mResult[1:0], 3'b000} +: 8];
        case (mSel)
            2'd0: res = mPc + `WB_LINK_OFFSET;
            2'd1: res = mResult;
            2'd2: res = mOutB;
            default: begin
                case (mKind)
                    3'd1: res = {{16{half[15]}}, half};
                    3'd2: res = {16'd0, half};
                    3'd3: res = {{24{lane[7]}}, lane};
                    3'd4: res = {24'd0, lane};
                    default: res = mDmOut;
                endcase
            end
        endcase
        return res;
    endfunction

    // commit with the old stage contents, then load the stage
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            shadowHi = '0;
            shadowLo = '0;
        end
        else if (!disWr) begin
            if (mWr[2] && (mDst != 5'd0)) begin
                shadow[mDst] = expectedResult();
            end
            if (mWr[1]) begin
                shadowHi = expectedResult();
            end
            if (mWr[0]) begin
                shadowLo = expectedResult();
            end
        end
        if (rst || flush) begin
            {mPc, mResult, mOutB, mDmOut} = '0;
            {mDst, mSel, mKind, mWr} = '0;
        end
        else if (wr) begin
            mPc = mem2Pc;
            mResult = mem2Result;
            mOutB = mem2OutB;
            mDmOut = mem2DmOut;
            mDst = mem2Dst;
            mSel = mem2WbSel;
            mKind = mem2LoadKind;
            mWr = mem2RegsWr;
        end
    end

    task automatic checkWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
        checkCount++;
        assert (actVal === expVal)
        else begin
            errCount++;
            $display("ERR %s expected %h actual %h at %0t", name, expVal, actVal, $time);
        end
    endtask

    // outputs against the model, sampled at the falling edge
    task automatic checkOutputs();
        checkWord("wbPc", mPc, wbPc);
        checkWord("wbDst", {27'd0, mDst}, {27'd0, wbDst});
        checkWord("wbResult", expectedResult(), wbResult);
        // cache stall masks every flag
        checkWord("wbFinalWr", {29'd0, (disWr ? 3'd0 : mWr)}, {29'd0, wbFinalWr});
        checkWord("rdDataA", shadow[rdAddrA], rdDataA);
        checkWord("rdDataB", shadow[rdAddrB], rdDataB);
        checkWord("hi", shadowHi, hi);
        checkWord("lo", shadowLo, lo);
    endtask

    task automatic driveRandom();
        logic [31:0] r;
        r = $random(seed);
        flush = (r[3:0] == 4'h0);
        wr = (r[5:4] != 2'b00);
        disWr = (r[7:6] == 2'b00);
        mem2WbSel = wbPkg::WbSelType'(r[9:8]);
        mem2RegsWr = wbPkg::RegsWrType'(r[12:10]);
        mem2Dst = r[17:13];
        rdAddrA = r[22:18];
        // port B follows the pending destination
        rdAddrB = mDst;
        r = $random(seed);
        mem2LoadKind = wbPkg::LoadKindType'(3'(r % 5));
        mem2Pc = $random(seed);
        mem2Pc[1:0] = 2'b00;
        mem2Result = $random(seed);
        mem2OutB = $random(seed);
        mem2DmOut = $random(seed);
        // aligned addresses only, misalignment is trapped earlier
        if (mem2WbSel == wbPkg::SelLoad) begin
            if (mem2LoadKind == wbPkg::LoadWord) begin
                mem2Result[1:0] = 2'b00;
            end
            else if (mem2LoadKind inside {wbPkg::LoadHalf, wbPkg::LoadHalfU}) begin
                mem2Result[0] = 1'b0;
            end
        end
    endtask

    initial begin
        seed = 32'ha488_73ee;
        errCount = 0;
        checkCount = 0;
        done = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        wr = 1'b0;
        disWr = 1'b0;
        mem2Pc = '0;
        mem2Result = '0;
        mem2OutB = '0;
        mem2DmOut = '0;
        mem2Dst = '0;
        mem2WbSel = wbPkg::SelLink;
        mem2LoadKind = wbPkg::LoadWord;
        mem2RegsWr = '0;
        rdAddrA = '0;
        rdAddrB = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // reset sweep over every register, stage idle
        for (int i = 0; i < 32; i++) begin
            rdAddrA = 5'(i);
            rdAddrB = 5'(31 - i);
            @(negedge clk);
            checkWord("rdDataA", 32'd0, rdDataA);
            checkWord("rdDataB", 32'd0, rdDataB);
            checkWord("hi", 32'd0, hi);
            checkWord("lo", 32'd0, lo);
            checkWord("wbFinalWr", 32'd0, {29'd0, wbFinalWr});
        end
        // mixed flush, stall, cache stall and commits
        for (int n = 0; n < RandCycles; n++) begin
            driveRandom();
            @(negedge clk);
            checkOutputs();
        end
        done = 1'b1;
        $display("checks: %0d errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end
        else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!done && (cycles < MaxCycles)) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: run did not complete within %0d cycles", MaxCycles);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

//--- wbTop.f
+incdir+design
design/wbPkg.sv
design/mem2WbIf.sv
design/wbReg.sv
design/loadAlign.sv
design/wbStage.sv
design/regFile.sv
design/wbTop.sv
tests/wbTopTb.sv
